// ==== decode_stage.f ====
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_mux.sv
logic/id_ex_latch.sv
logic/decode_stage.sv
testbench/tb_decode_stage.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_decode_stage
FILELIST = decode_stage.f
PASS_MSG = Finished with no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/100ps

module tb_decode_stage;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    localparam int N_FILL = 31;
    localparam int N_RR   = 40;
    localparam int N_RI   = 30;
    localparam int N_SH   = 20;
    localparam int N_BYP  = 40;
    localparam int N_MOV  = 24;
    localparam int N_BAD  = 20;
    localparam int STIM_CYCLES = 5 + N_FILL + N_RR + 2 + N_RI + N_SH + 1 + N_BYP + N_MOV
                                 + N_BAD + 1 + 2;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;

    logic    clk;
    logic    reset_i;
    word_t   inst_i;
    bypass_t wb_i;
    bypass_t ex_fwd_i;
    bypass_t mem_fwd_i;
    id_ex_t  id_ex_o;

    word_t   shadow [NUM_REGS];   // Reference copy of the register file
    id_ex_t  exp_cur;
    id_ex_t  exp_prev;
    string   test_cur;
    string   test_prev;
    logic    have_cur;
    logic    chk_valid;
    logic    rst_chk;
    int      errors;
    int      cycles;
    integer  seed;
    funct_t  rr_fn [15];
    opcode_t ri_op [8];
    funct_t  sh_fn [3];

    decode_stage UUT (
        .clk       (clk),
        .reset_i   (reset_i),
        .inst_i    (inst_i),
        .wb_i      (wb_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .id_ex_o   (id_ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_i.wr.en && (wb_i.wr.addr != '0)) begin
            shadow[wb_i.wr.addr] <= wb_i.data;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    a_reset_out: assert property (@(posedge clk) rst_chk |-> (id_ex_o == '0))
        else begin
            errors++;
            $display("mismatch reset expected %h actual %h", id_ex_t'(0), $sampled(id_ex_o));
        end

    // Each instruction is checked one edge after it is latched
    a_stage_out: assert property (@(posedge clk) chk_valid |-> (id_ex_o == exp_prev))
        else begin
            errors++;
            $display("mismatch %s expected %h actual %h", test_prev, exp_prev, $sampled(id_ex_o));
        end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(rand_word());
    endfunction

    function automatic bypass_t make_fwd(logic en, reg_addr_t addr, word_t data);
        bypass_t b;
        b.wr.en   = en;
        b.wr.addr = addr;
        b.data    = data;
        return b;
    endfunction

    // Execute, then memory, then register file, else immediate
    function automatic word_t pick_operand(logic en, reg_addr_t addr, word_t imm,
                                           bypass_t wb, bypass_t ex, bypass_t mem);
        if (!en) return imm;
        if (ex.wr.en && (ex.wr.addr == addr)) return ex.data;
        if (mem.wr.en && (mem.wr.addr == addr)) return mem.data;
        if (addr == '0) return '0;
        if (wb.wr.en && (wb.wr.addr == addr)) return wb.data;
        return shadow[addr];
    endfunction

    function automatic id_ex_t expected_stage_out(word_t inst, bypass_t wb, bypass_t ex,
                                                  bypass_t mem);
        opcode_t    op;
        funct_t     fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        logic [4:0] sa;
        logic       rd1;
        logic       rd2;
        word_t      imm;
        move_cond_e mv;
        id_ex_t     e;
        op = inst[31:26];
        rs = inst[25:21];
        rt = inst[20:16];
        sa = inst[10:6];
        fn = inst[5:0];
        e = '0;
        e.wd = inst[15:11];
        e.inst_invalid = 1'b1;
        rd1 = 1'b0;
        rd2 = 1'b0;
        imm = '0;
        mv = MOVE_NONE;
        if ((inst[31:21] == '0) && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)) begin
            e.aluop = (fn == FN_SLL) ? ALU_SLL : (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
            e.alusel = SEL_SHIFT;
            rd2 = 1'b1;
            imm = {27'd0, sa};   // Shift amount rides on operand 1
            e.wreg = 1'b1;
            e.inst_invalid = 1'b0;
        end else if ((op == OP_SPECIAL) && (sa == '0)) begin
            case (fn)
                FN_OR:   e.aluop = ALU_OR;
                FN_AND:  e.aluop = ALU_AND;
                FN_XOR:  e.aluop = ALU_XOR;
                FN_NOR:  e.aluop = ALU_NOR;
                FN_SLLV: e.aluop = ALU_SLL;
                FN_SRLV: e.aluop = ALU_SRL;
                FN_SRAV: e.aluop = ALU_SRA;
                FN_MOVZ: e.aluop = ALU_MOVZ;
                FN_MOVN: e.aluop = ALU_MOVN;
                FN_ADD:  e.aluop = ALU_ADD;
                FN_ADDU: e.aluop = ALU_ADDU;
                FN_SUB:  e.aluop = ALU_SUB;
                FN_SUBU: e.aluop = ALU_SUBU;
                FN_SLT:  e.aluop = ALU_SLT;
                FN_SLTU: e.aluop = ALU_SLTU;
                default: e.aluop = ALU_NOP;
            endcase
            case (fn)
                FN_OR, FN_AND, FN_XOR, FN_NOR:       e.alusel = SEL_LOGIC;
                FN_SLLV, FN_SRLV, FN_SRAV:           e.alusel = SEL_SHIFT;
                FN_MOVZ, FN_MOVN:                    e.alusel = SEL_MOVE;
                FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                FN_SLT, FN_SLTU:                     e.alusel = SEL_ARITH;
                default:                             e.alusel = SEL_NOP;
            endcase
            if (e.aluop != ALU_NOP) begin
                rd1 = 1'b1;
                rd2 = 1'b1;
                e.wreg = 1'b1;
                e.inst_invalid = 1'b0;
            end
            if (fn == FN_MOVZ) mv = MOVE_IF_ZERO;
            if (fn == FN_MOVN) mv = MOVE_IF_NONZERO;
            if (fn == FN_SYNC) e.inst_invalid = 1'b0;
        end else begin
            case (op)
                OP_ORI, OP_LUI: e.aluop = ALU_OR;
                OP_ANDI:        e.aluop = ALU_AND;
                OP_XORI:        e.aluop = ALU_XOR;
                OP_ADDI:        e.aluop = ALU_ADDI;
                OP_ADDIU:       e.aluop = ALU_ADDIU;
                OP_SLTI:        e.aluop = ALU_SLT;
                OP_SLTIU:       e.aluop = ALU_SLTU;
                default:        e.aluop = ALU_NOP;
            endcase
            if (op == OP_LUI) begin
                imm = {inst[15:0], 16'd0};
            end else if (op == OP_ORI || op == OP_ANDI || op == OP_XORI) begin
                imm = {16'd0, inst[15:0]};
            end else begin
                imm = {{16{inst[15]}}, inst[15:0]};
            end
            if (e.aluop != ALU_NOP) begin
                e.alusel = (op == OP_ORI || op == OP_ANDI || op == OP_XORI || op == OP_LUI)
                           ? SEL_LOGIC : SEL_ARITH;
                rd1 = 1'b1;
                e.wd = rt;
                e.wreg = 1'b1;
                e.inst_invalid = 1'b0;
            end else begin
                imm = '0;
            end
            if (op == OP_PREF) e.inst_invalid = 1'b0;
        end
        e.reg1 = pick_operand(rd1, rs, imm, wb, ex, mem);
        e.reg2 = pick_operand(rd2, rt, imm, wb, ex, mem);
        if (mv == MOVE_IF_ZERO) e.wreg = e.wreg && (e.reg2 == '0);
        if (mv == MOVE_IF_NONZERO) e.wreg = e.wreg && (e.reg2 != '0);
        return e;
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic issue_cycle(string name, word_t inst, bypass_t wb, bypass_t ex, bypass_t mem);
        exp_prev = exp_cur;
        test_prev = test_cur;
        chk_valid = have_cur;
        inst_i = inst;
        wb_i = wb;
        ex_fwd_i = ex;
        mem_fwd_i = mem;
        exp_cur = expected_stage_out(inst, wb, ex, mem);
        test_cur = name;
        have_cur = 1'b1;
        @(negedge clk);
    endtask

    initial begin
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        reg_addr_t wbad;
        funct_t    fn;
        word_t     w;
        bypass_t   none;
        seed = 32'ha8ed8bae;
        rr_fn = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV, FN_MOVZ,
                  FN_MOVN, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
        ri_op = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
        sh_fn = '{FN_SLL, FN_SRL, FN_SRA};
        none = '0;
        reset_i = 1'b1;
        inst_i = '0;
        wb_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        errors = 0;
        cycles = 0;
        have_cur = 1'b0;
        chk_valid = 1'b0;
        rst_chk = 1'b0;
        exp_cur = '0;
        exp_prev = '0;
        test_cur = "";
        test_prev = "";

        @(negedge clk);
        rst_chk = 1'b1;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);   // First edge after release still shows reset values
        rst_chk = 1'b0;

        for (int i = 1; i <= N_FILL; i++) begin
            issue_cycle("fill", 32'hffff_ffff, make_fwd(1'b1, reg_addr_t'(i), rand_word()),
                        none, none);
        end

        for (int i = 0; i < N_RR; i++) begin
            rs = rand_reg();
            rt = rand_reg();
            rd = rand_reg();
            fn = rr_fn[int'(rand_word() % 15)];
            w = rand_word();
            wbad = w[0] ? rs : rand_reg();   // Half the time a same-cycle write to rs
            issue_cycle("rtype", {OP_SPECIAL, rs, rt, rd, 5'd0, fn},
                        make_fwd(1'b1, wbad, rand_word()), none, none);
        end
        issue_cycle("rtype_r0", {OP_SPECIAL, 5'd0, 5'd0, 5'd5, 5'd0, FN_OR},
                    make_fwd(1'b1, 5'd0, 32'hdead_beef), none, none);
        issue_cycle("rtype_wb_thru", {OP_SPECIAL, 5'd7, 5'd7, 5'd9, 5'd0, FN_ADDU},
                    make_fwd(1'b1, 5'd7, 32'h1234_5678), none, none);

        for (int i = 0; i < N_RI; i++) begin
            w = rand_word();
            issue_cycle("itype", {ri_op[i % 8], rand_reg(), rand_reg(), w[15:0]},
                        none, none, none);
        end

        for (int i = 0; i < N_SH; i++) begin
            w = rand_word();
            issue_cycle("shift_sa", {11'd0, rand_reg(), rand_reg(), w[4:0], sh_fn[i % 3]},
                        none, none, none);
        end
        issue_cycle("all_zero", 32'h0, none, none, none);

        for (int i = 0; i < N_BYP; i++) begin
            rs = rand_reg();
            rt = rand_reg();
            fn = rr_fn[int'(rand_word() % 15)];
            w = rand_word();
            issue_cycle("bypass", {OP_SPECIAL, rs, rt, rand_reg(), 5'd0, fn},
                        make_fwd(w[6], rand_reg(), rand_word()),
                        make_fwd(w[2] | w[3], w[1] ? rs : rt, rand_word()),
                        make_fwd(w[4] | w[5], w[0] ? rs : rt, rand_word()));
        end

        for (int i = 0; i < N_MOV; i++) begin
            w = rand_word();
            fn = w[0] ? FN_MOVZ : FN_MOVN;
            rt = w[1] ? 5'd0 : rand_reg();
            issue_cycle("move", {OP_SPECIAL, rand_reg(), rt, rand_reg(), 5'd0, fn}, none,
                        make_fwd(w[2], rt, w[3] ? 32'd0 : rand_word()), none);
        end

        for (int i = 0; i < N_BAD; i++) begin
            issue_cycle("invalid", rand_word(), none, none, none);
        end
        issue_cycle("mult", {OP_SPECIAL, rand_reg(), rand_reg(), 10'd0, 6'b011000},
                    none, none, none);

        repeat (2) issue_cycle("drain", 32'hffff_ffff, none, none, none);
        chk_valid = 1'b0;

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  mips_isa_pkg::word_t    inst_i,
    input  mips_pipe_pkg::bypass_t wb_i,
    input  mips_pipe_pkg::bypass_t ex_fwd_i,
    input  mips_pipe_pkg::bypass_t mem_fwd_i,
    output mips_pipe_pkg::id_ex_t  id_ex_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    dec_ctrl_t ctrl;
    word_t     rf_data1;
    word_t     rf_data2;
    word_t     reg1;
    word_t     reg2;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_i     (wb_i),
        .raddr1_i (ctrl.reg1_addr),
        .raddr2_i (ctrl.reg2_addr),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2)
    );

    // rs side
    operand_mux u_opnd1 (
        .read_en_i (ctrl.reg1_read),
        .addr_i    (ctrl.reg1_addr),
        .rf_data_i (rf_data1),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1)
    );

    // rt side
    operand_mux u_opnd2 (
        .read_en_i (ctrl.reg2_read),
        .addr_i    (ctrl.reg2_addr),
        .rf_data_i (rf_data2),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2)
    );

    id_ex_latch u_id_ex (
        .clk     (clk),
        .reset_i (reset_i),
        .ctrl_i  (ctrl),
        .reg1_i  (reg1),
        .reg2_i  (reg2),
        .id_ex_o (id_ex_o)
    );

endmodule

// ==== logic/id_ex_latch.sv ====
`timescale 1ns/100ps

module id_ex_latch (
    input  logic                     clk,
    input  logic                     reset_i,
    input  mips_pipe_pkg::dec_ctrl_t ctrl_i,
    input  mips_isa_pkg::word_t      reg1_i,
    input  mips_isa_pkg::word_t      reg2_i,
    output mips_pipe_pkg::id_ex_t    id_ex_o
);
    import mips_pipe_pkg::*;

    logic wreg_d;

    // MOVZ/MOVN resolved on the forwarded rt value
    always_comb begin
        case (ctrl_i.move_cond)
            MOVE_IF_ZERO:    wreg_d = ctrl_i.wreg && (reg2_i == '0);
            MOVE_IF_NONZERO: wreg_d = ctrl_i.wreg && (reg2_i != '0);
            default:         wreg_d = ctrl_i.wreg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_o.aluop        <= ALU_NOP;
            id_ex_o.alusel       <= SEL_NOP;
            id_ex_o.reg1         <= '0;
            id_ex_o.reg2         <= '0;
            id_ex_o.wd           <= '0;
            id_ex_o.wreg         <= 1'b0;
            id_ex_o.inst_invalid <= 1'b0;
        end else begin
            id_ex_o.aluop        <= ctrl_i.aluop;
            id_ex_o.alusel       <= ctrl_i.alusel;
            id_ex_o.reg1         <= reg1_i;
            id_ex_o.reg2         <= reg2_i;
            id_ex_o.wd           <= ctrl_i.wd;
            id_ex_o.wreg         <= wreg_d;
            id_ex_o.inst_invalid <= ctrl_i.inst_invalid;
        end
    end

    a_no_write_after_reset: assert property (@(posedge clk) reset_i |=> !id_ex_o.wreg)
        else $error("id_ex_latch: write enable set on the edge after reset");

endmodule

// ==== logic/operand_mux.sv ====
`timescale 1ns/100ps

module operand_mux (
    input  logic                    read_en_i,
    input  mips_isa_pkg::reg_addr_t addr_i,
    input  mips_isa_pkg::word_t     rf_data_i,
    input  mips_isa_pkg::word_t     imm_i,
    input  mips_pipe_pkg::bypass_t  ex_fwd_i,
    input  mips_pipe_pkg::bypass_t  mem_fwd_i,
    output mips_isa_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // No r0 exclusion here, a match on address 0 still forwards
    assign ex_hit  = read_en_i && ex_fwd_i.wr.en && (ex_fwd_i.wr.addr == addr_i);
    assign mem_hit = read_en_i && mem_fwd_i.wr.en && (mem_fwd_i.wr.addr == addr_i);

    always_comb begin
        if (ex_hit) begin
            operand_o = ex_fwd_i.data;   // Youngest result first
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else if (read_en_i) begin
            operand_o = rf_data_i;
        end else begin
            operand_o = imm_i;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                      clk,
    input  logic                      reset_i,
    input  mips_pipe_pkg::bypass_t    wb_i,
    input  mips_isa_pkg::reg_addr_t   raddr1_i,
    input  mips_isa_pkg::reg_addr_t   raddr2_i,
    output mips_isa_pkg::word_t       rdata1_o,
    output mips_isa_pkg::word_t       rdata2_o
);
    import mips_isa_pkg::*;

    word_t regs [NUM_REGS];

    // r0 is hardwired, then same-cycle writeback, then the array
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.wr.en && (wb_i.wr.addr == addr)) begin
            return wb_i.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wr.en && (wb_i.wr.addr != '0)) begin
            regs[wb_i.wr.addr] <= wb_i.data;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

    // Also covers a writeback aimed at r0 in the same cycle
    a_r0_zero: assert property (@(posedge clk)
        ((raddr1_i == '0) |-> (rdata1_o == '0)) and ((raddr2_i == '0) |-> (rdata2_o == '0)))
        else $error("reg_file: r0 read back nonzero");

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  mips_isa_pkg::word_t      inst_i,
    output mips_pipe_pkg::dec_ctrl_t ctrl_o
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_t            opcode;
    reg_addr_t          rs;
    reg_addr_t          rt;
    reg_addr_t          rd;
    logic [SHAMT_W-1:0] sa;
    funct_t             funct;

    word_t imm_zext;
    word_t imm_sext;
    word_t imm_upper;
    word_t imm_shamt;
    word_t ri_imm;

    alu_op_e rr_aluop;   // Register-register op from funct
    alu_op_e ri_aluop;   // Immediate op from opcode
    alu_op_e sh_aluop;   // Shift by sa

    logic special_ok;
    logic rr_valid;
    logic ri_valid;
    logic shift_imm;
    logic nop_valid;

    function automatic alu_sel_e sel_of(alu_op_e op);
        case (op)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         return SEL_SHIFT;
            ALU_MOVZ, ALU_MOVN:                return SEL_MOVE;
            ALU_NOP:                           return SEL_NOP;
            default:                           return SEL_ARITH;
        endcase
    endfunction

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign sa     = inst_i[10:6];
    assign funct  = inst_i[5:0];

    assign imm_zext  = {{IMM_W{1'b0}}, inst_i[IMM_W-1:0]};
    assign imm_sext  = {{IMM_W{inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0]};
    assign imm_upper = {inst_i[IMM_W-1:0], {IMM_W{1'b0}}};
    assign imm_shamt = {{(WORD_W-SHAMT_W){1'b0}}, sa};

    always_comb begin
        case (funct)
            FN_OR:   rr_aluop = ALU_OR;
            FN_AND:  rr_aluop = ALU_AND;
            FN_XOR:  rr_aluop = ALU_XOR;
            FN_NOR:  rr_aluop = ALU_NOR;
            FN_SLLV: rr_aluop = ALU_SLL;
            FN_SRLV: rr_aluop = ALU_SRL;
            FN_SRAV: rr_aluop = ALU_SRA;
            FN_MOVZ: rr_aluop = ALU_MOVZ;
            FN_MOVN: rr_aluop = ALU_MOVN;
            FN_ADD:  rr_aluop = ALU_ADD;
            FN_ADDU: rr_aluop = ALU_ADDU;
            FN_SUB:  rr_aluop = ALU_SUB;
            FN_SUBU: rr_aluop = ALU_SUBU;
            FN_SLT:  rr_aluop = ALU_SLT;
            FN_SLTU: rr_aluop = ALU_SLTU;
            default: rr_aluop = ALU_NOP;   // SYNC, MULT and friends
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ORI, OP_LUI: ri_aluop = ALU_OR;
            OP_ANDI:        ri_aluop = ALU_AND;
            OP_XORI:        ri_aluop = ALU_XOR;
            OP_ADDI:        ri_aluop = ALU_ADDI;
            OP_ADDIU:       ri_aluop = ALU_ADDIU;
            OP_SLTI:        ri_aluop = ALU_SLT;
            OP_SLTIU:       ri_aluop = ALU_SLTU;
            default:        ri_aluop = ALU_NOP;
        endcase
    end

    always_comb begin
        case (funct)
            FN_SLL:  sh_aluop = ALU_SLL;
            FN_SRL:  sh_aluop = ALU_SRL;
            FN_SRA:  sh_aluop = ALU_SRA;
            default: sh_aluop = ALU_NOP;
        endcase
    end

    // LUI puts the half-word on top, logic ops zero-extend, arithmetic sign-extends
    assign ri_imm = (opcode == OP_LUI)             ? imm_upper :
                    (sel_of(ri_aluop) == SEL_LOGIC) ? imm_zext  : imm_sext;

    assign special_ok = (opcode == OP_SPECIAL) && (sa == '0);
    assign rr_valid   = special_ok && (rr_aluop != ALU_NOP);
    assign ri_valid   = (ri_aluop != ALU_NOP);
    assign shift_imm  = (inst_i[31:21] == '0) && (sh_aluop != ALU_NOP);
    assign nop_valid  = (special_ok && (funct == FN_SYNC)) || (opcode == OP_PREF);

    always_comb begin
        ctrl_o.aluop        = ALU_NOP;
        ctrl_o.alusel       = SEL_NOP;
        ctrl_o.reg1_read    = 1'b0;
        ctrl_o.reg2_read    = 1'b0;
        ctrl_o.reg1_addr    = rs;
        ctrl_o.reg2_addr    = rt;
        ctrl_o.wd           = rd;
        ctrl_o.wreg         = 1'b0;
        ctrl_o.move_cond    = MOVE_NONE;
        ctrl_o.imm          = '0;
        ctrl_o.inst_invalid = 1'b1;

        if (shift_imm) begin
            // sa goes out on operand 1 through the immediate
            ctrl_o.aluop        = sh_aluop;
            ctrl_o.reg2_read    = 1'b1;
            ctrl_o.wreg         = 1'b1;
            ctrl_o.imm          = imm_shamt;
            ctrl_o.inst_invalid = 1'b0;
        end else if (rr_valid) begin
            ctrl_o.aluop        = rr_aluop;
            ctrl_o.reg1_read    = 1'b1;
            ctrl_o.reg2_read    = 1'b1;
            ctrl_o.wreg         = 1'b1;
            ctrl_o.inst_invalid = 1'b0;
            if (rr_aluop == ALU_MOVZ) begin
                ctrl_o.move_cond = MOVE_IF_ZERO;
            end else if (rr_aluop == ALU_MOVN) begin
                ctrl_o.move_cond = MOVE_IF_NONZERO;
            end
        end else if (ri_valid) begin
            ctrl_o.aluop        = ri_aluop;
            ctrl_o.reg1_read    = 1'b1;
            ctrl_o.wd           = rt;
            ctrl_o.wreg         = 1'b1;
            ctrl_o.imm          = ri_imm;
            ctrl_o.inst_invalid = 1'b0;
        end else if (nop_valid) begin
            ctrl_o.inst_invalid = 1'b0;   // SYNC, PREF
        end

        ctrl_o.alusel = sel_of(ctrl_o.aluop);
    end

endmodule

// ==== logic/mips_pipe_pkg.sv ====
package mips_pipe_pkg;

    // ALU operation codes seen by execute
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_MOVZ  = 8'b00001010,
        ALU_MOVN  = 8'b00001011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLL   = 8'b01111100
    } alu_op_e;

    // Result class, picks the execute output mux leg
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alu_sel_e;

    typedef enum logic [1:0] {
        MOVE_NONE       = 2'b00,
        MOVE_IF_ZERO    = 2'b01,
        MOVE_IF_NONZERO = 2'b10
    } move_cond_e;

    typedef struct packed {
        logic                    en;
        mips_isa_pkg::reg_addr_t addr;
    } reg_write_t;

    // Result coming back from execute, memory or writeback
    typedef struct packed {
        reg_write_t          wr;
        mips_isa_pkg::word_t data;
    } bypass_t;

    typedef struct packed {
        alu_op_e                 aluop;
        alu_sel_e                alusel;
        logic                    reg1_read;
        logic                    reg2_read;
        mips_isa_pkg::reg_addr_t reg1_addr;
        mips_isa_pkg::reg_addr_t reg2_addr;
        mips_isa_pkg::reg_addr_t wd;
        logic                    wreg;
        move_cond_e              move_cond;
        mips_isa_pkg::word_t     imm;
        logic                    inst_invalid;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e                 aluop;
        alu_sel_e                alusel;
        mips_isa_pkg::word_t     reg1;
        mips_isa_pkg::word_t     reg2;
        mips_isa_pkg::reg_addr_t wd;
        logic                    wreg;
        logic                    inst_invalid;
    } id_ex_t;

endpackage

// ==== logic/mips_isa_pkg.sv ====
package mips_isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT_W-1:0]    funct_t;

    // Primary opcodes, inst[31:26]
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_PREF    = 6'b110011;

    // SPECIAL funct codes, inst[5:0]
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_MOVZ = 6'b001010;
    localparam funct_t FN_MOVN = 6'b001011;
    localparam funct_t FN_SYNC = 6'b001111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

endpackage
